// ==== fetch_geom_pkg.sv ====
package fetch_geom_pkg;

    //////////////////////////////
    // line and packet geometry
    //////////////////////////////

    // bytes per buffer line, also the packet size
    localparam int LINE_BYTES = 16;

    // one line or one packet in bits
    localparam int LINE_BITS = 128;

    // byte offset inside a line
    localparam int OFS_BITS = 4;

    // decoded instruction length
    localparam int LEN_BITS = 8;

    // lines in the buffer unless the top level says otherwise
    localparam int DEF_LINE_COUNT = 4;

endpackage

// ==== redirect_pkg.sv ====
package redirect_pkg;

    // winner of the redirect selection
    // higher code means higher priority
    typedef enum logic [1:0] {
        SRC_NONE    = 2'd0,
        SRC_BRANCH  = 2'd1,
        SRC_RESTEER = 2'd2,
        SRC_INIT    = 2'd3
    } redirect_src_t;

    // fixed order: init, then writeback resteer, then taken branch
    function automatic redirect_src_t pick_src(
        input logic is_init,
        input logic is_resteer,
        input logic is_branch
    );
        if (is_init) return SRC_INIT;
        if (is_resteer) return SRC_RESTEER;
        if (is_branch) return SRC_BRANCH;
        return SRC_NONE;
    endfunction

endpackage

// ==== bip_control.sv ====
module bip_control #(
    parameter int LINE_COUNT = fetch_geom_pkg::DEF_LINE_COUNT,
    localparam int PTR_BITS = $clog2(LINE_COUNT * fetch_geom_pkg::LINE_BYTES),
    localparam int IDX_BITS = $clog2(LINE_COUNT)
) (
    input  logic clk,
    input  logic rst,

    //////////////////////////////
    // redirect sources
    //////////////////////////////
    input  logic is_init,
    input  logic [PTR_BITS-1:0] init_bip,
    input  logic is_resteer,
    input  logic [PTR_BITS-1:0] wb_bip,
    input  logic is_branch,
    input  logic [PTR_BITS-1:0] bp_bip,

    //////////////////////////////
    // decode side
    //////////////////////////////
    input  logic [fetch_geom_pkg::LEN_BITS-1:0] length,
    input  logic stall,

    // both lines of the window are present
    input  logic window_ok,

    output logic [PTR_BITS-1:0] window_start,
    output logic [PTR_BITS-1:0] old_bip,
    output logic advance,
    output logic redirect,
    output logic release_line,
    output logic [IDX_BITS-1:0] release_index,
    output redirect_pkg::redirect_src_t redirect_src
);

    // wide enough that the add never drops the carry out of either operand
    localparam int SUM_BITS =
        ((PTR_BITS > fetch_geom_pkg::LEN_BITS) ? PTR_BITS : fetch_geom_pkg::LEN_BITS) + 1;

    logic [PTR_BITS-1:0] bip_q;
    logic [PTR_BITS-1:0] target;
    logic [SUM_BITS-1:0] bip_sum;

    //////////////////////////////
    // redirect select
    //////////////////////////////
    assign redirect_src = redirect_pkg::pick_src(is_init, is_resteer, is_branch);
    assign redirect = (redirect_src != redirect_pkg::SRC_NONE);

    always_comb begin
        case (redirect_src)
            redirect_pkg::SRC_INIT:    target = init_bip;
            redirect_pkg::SRC_RESTEER: target = wb_bip;
            default:                   target = bp_bip;
        endcase
    end

    //////////////////////////////
    // window start
    //////////////////////////////
    assign bip_sum = SUM_BITS'(bip_q) + SUM_BITS'(length);

    // low bits only, so the start wraps around the buffer
    assign window_start = redirect ? target : bip_sum[PTR_BITS-1:0];

    // pointer loads unless stalled or waiting on a missing line
    assign advance = !stall && (redirect || window_ok);

    assign old_bip = bip_q;

    // line we are leaving on a sequential advance
    assign release_index = bip_q[PTR_BITS-1 -: IDX_BITS];
    assign release_line = advance && !redirect &&
        (release_index != window_start[PTR_BITS-1 -: IDX_BITS]);

    always_ff @(posedge clk) begin
        if (rst) begin
            bip_q <= '0;
        end else if (advance) begin
            bip_q <= window_start;
        end
    end

endmodule

// ==== ibuf_lines.sv ====
module ibuf_lines #(
    parameter int LINE_COUNT = fetch_geom_pkg::DEF_LINE_COUNT,
    localparam int IDX_BITS = $clog2(LINE_COUNT),
    localparam int BUF_BITS = LINE_COUNT * fetch_geom_pkg::LINE_BITS
) (
    input  logic clk,
    input  logic rst,

    //////////////////////////////
    // fill from outside
    //////////////////////////////
    input  logic fill_valid,
    input  logic [IDX_BITS-1:0] fill_index,
    input  logic [fetch_geom_pkg::LINE_BITS-1:0] fill_data,

    //////////////////////////////
    // from pointer control
    //////////////////////////////
    input  logic release_line,
    input  logic [IDX_BITS-1:0] release_index,
    input  logic flush,

    // line 0 sits in the low bits
    output logic [BUF_BITS-1:0] line_data,
    output logic [LINE_COUNT-1:0] line_valid
);

    logic [fetch_geom_pkg::LINE_BITS-1:0] lines_q [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] valid_d;

    // line storage, written only by a fill
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            lines_q[fill_index] <= fill_data;
        end
    end

    // clears first, fill applied last so it always wins
    always_comb begin
        valid_d = valid_q;
        if (flush) begin
            valid_d = '0;
        end else if (release_line) begin
            valid_d[release_index] = 1'b0;
        end
        if (fill_valid) begin
            valid_d[fill_index] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    for (genvar i = 0; i < LINE_COUNT; i++) begin : g_line_out
        assign line_data[i*fetch_geom_pkg::LINE_BITS +: fetch_geom_pkg::LINE_BITS] = lines_q[i];
    end

    assign line_valid = valid_q;

endmodule

// ==== packet_extract.sv ====
module packet_extract #(
    parameter int LINE_COUNT = fetch_geom_pkg::DEF_LINE_COUNT,
    localparam int PTR_BITS = $clog2(LINE_COUNT * fetch_geom_pkg::LINE_BYTES),
    localparam int BUF_BITS = LINE_COUNT * fetch_geom_pkg::LINE_BITS
) (
    //////////////////////////////
    // buffer state
    //////////////////////////////
    input  logic [BUF_BITS-1:0] line_data,
    input  logic [LINE_COUNT-1:0] line_valid,

    //////////////////////////////
    // from pointer control
    //////////////////////////////
    input  logic [PTR_BITS-1:0] window_start,
    input  logic redirect,

    output logic [fetch_geom_pkg::LINE_BITS-1:0] packet_out,
    output logic packet_valid,
    output logic window_ok
);

    localparam int IDX_BITS = $clog2(LINE_COUNT);
    localparam int BYTE_BITS = fetch_geom_pkg::LINE_BITS / fetch_geom_pkg::LINE_BYTES;

    logic [IDX_BITS-1:0] start_line;
    logic [LINE_COUNT-1:0] line_sel;
    logic [LINE_COUNT-1:0] pair_ok;

    // one buffer image per shifter stage
    logic [BUF_BITS-1:0] rot_stage [PTR_BITS+1];

    //////////////////////////////
    // window validity
    //////////////////////////////
    assign start_line = window_start[PTR_BITS-1 -: IDX_BITS];

    // one-hot decode of the start line
    always_comb begin
        line_sel = '0;
        line_sel[start_line] = 1'b1;
    end

    // each line paired with its successor, last one wraps to line 0
    for (genvar i = 0; i < LINE_COUNT; i++) begin : g_pair
        assign pair_ok[i] = line_valid[i] && line_valid[(i + 1) % LINE_COUNT];
    end

    assign window_ok = |(line_sel & pair_ok);

    // a redirect packet is stale, the flush is still pending
    assign packet_valid = window_ok && !redirect;

    //////////////////////////////
    // byte rotation
    //////////////////////////////
    assign rot_stage[0] = line_data;

    // stage s rotates right by 2**s bytes when bit s of the start is set
    for (genvar s = 0; s < PTR_BITS; s++) begin : g_rot
        localparam int SH = (1 << s) * BYTE_BITS;

        assign rot_stage[s+1] = window_start[s] ?
            {rot_stage[s][SH-1:0], rot_stage[s][BUF_BITS-1:SH]} :
            rot_stage[s];
    end

    // lowest line of the rotated buffer is the packet
    assign packet_out = rot_stage[PTR_BITS][fetch_geom_pkg::LINE_BITS-1:0];

endmodule

// ==== fetch_top.sv ====
module fetch_top #(
    parameter int LINE_COUNT = fetch_geom_pkg::DEF_LINE_COUNT,
    localparam int PTR_BITS = $clog2(LINE_COUNT * fetch_geom_pkg::LINE_BYTES),
    localparam int IDX_BITS = $clog2(LINE_COUNT)
) (
    input  logic clk,
    input  logic rst,

    //////////////////////////////
    // line fill
    //////////////////////////////
    input  logic fill_valid,
    input  logic [IDX_BITS-1:0] fill_index,
    input  logic [fetch_geom_pkg::LINE_BITS-1:0] fill_data,

    //////////////////////////////
    // redirects
    //////////////////////////////
    input  logic is_init,
    input  logic [PTR_BITS-1:0] init_bip,
    input  logic is_resteer,
    input  logic [PTR_BITS-1:0] wb_bip,
    input  logic is_branch,
    input  logic [PTR_BITS-1:0] bp_bip,

    // decode side
    input  logic [fetch_geom_pkg::LEN_BITS-1:0] length,
    input  logic stall,

    output logic [fetch_geom_pkg::LINE_BITS-1:0] packet_out,
    output logic packet_valid,
    output logic [PTR_BITS-1:0] old_bip,
    output logic [PTR_BITS-1:0] new_bip,
    output logic [LINE_COUNT-1:0] line_valid
);

    logic [PTR_BITS-1:0] window_start;
    logic advance;
    logic redirect;
    logic release_line;
    logic [IDX_BITS-1:0] release_index;
    logic window_ok;
    logic [LINE_COUNT*fetch_geom_pkg::LINE_BITS-1:0] line_data;
    redirect_pkg::redirect_src_t redirect_src;

    bip_control #(.LINE_COUNT(LINE_COUNT)) u_bip (
        .clk(clk), .rst(rst),
        .is_init(is_init), .init_bip(init_bip),
        .is_resteer(is_resteer), .wb_bip(wb_bip),
        .is_branch(is_branch), .bp_bip(bp_bip),
        .length(length), .stall(stall), .window_ok(window_ok),
        .window_start(window_start), .old_bip(old_bip),
        .advance(advance), .redirect(redirect),
        .release_line(release_line), .release_index(release_index),
        .redirect_src(redirect_src)
    );

    // flush only on a redirect that actually loads the pointer
    ibuf_lines #(.LINE_COUNT(LINE_COUNT)) u_lines (
        .clk(clk), .rst(rst),
        .fill_valid(fill_valid), .fill_index(fill_index), .fill_data(fill_data),
        .release_line(release_line), .release_index(release_index),
        .flush(advance && redirect),
        .line_data(line_data), .line_valid(line_valid)
    );

    packet_extract #(.LINE_COUNT(LINE_COUNT)) u_extract (
        .line_data(line_data), .line_valid(line_valid),
        .window_start(window_start), .redirect(redirect),
        .packet_out(packet_out), .packet_valid(packet_valid), .window_ok(window_ok)
    );

    assign new_bip = window_start;

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // release away from the active edge
        @(negedge clk);
        rst <= 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== fetch_chk.sv ====
module fetch_chk #(
    parameter int LINE_COUNT = fetch_geom_pkg::DEF_LINE_COUNT,
    localparam int PTR_BITS = $clog2(LINE_COUNT * fetch_geom_pkg::LINE_BYTES)
) (
    input logic clk,
    input logic rst,
    input logic packet_valid,
    input logic is_init,
    input logic is_resteer,
    input logic is_branch,
    input redirect_pkg::redirect_src_t redirect_src,
    input logic stall,
    input logic [PTR_BITS-1:0] old_bip
);

    //////////////////////////////
    // packet validity
    //////////////////////////////

    // any redirect request names a winner and hides the packet
    no_valid_on_redirect: assert property (
        @(posedge clk) disable iff (rst)
        (is_init || is_resteer || is_branch) |->
            (redirect_src != redirect_pkg::SRC_NONE) && !packet_valid
    ) else $error("packet_valid is high while a redirect is present");

    // reset clears every valid bit so nothing is valid right after
    no_valid_after_reset: assert property (
        @(posedge clk) rst |=> !packet_valid
    ) else $error("packet_valid is high on the cycle after reset");

    //////////////////////////////
    // pointer
    //////////////////////////////

    // stall freezes the BIP for the following edge
    bip_holds_on_stall: assert property (
        @(posedge clk) disable iff (rst) stall |=> $stable(old_bip)
    ) else $error("BIP moved while stall was high");

endmodule

bind fetch_top fetch_chk #(.LINE_COUNT(LINE_COUNT)) u_chk (
    .clk(clk),
    .rst(rst),
    .packet_valid(packet_valid),
    .is_init(is_init),
    .is_resteer(is_resteer),
    .is_branch(is_branch),
    .redirect_src(redirect_src),
    .stall(stall),
    .old_bip(old_bip)
);

// ==== tb_top.sv ====
module tb_top;

    localparam int LINE_COUNT = fetch_geom_pkg::DEF_LINE_COUNT;
    localparam int LINE_BYTES = fetch_geom_pkg::LINE_BYTES;
    localparam int LINE_BITS = fetch_geom_pkg::LINE_BITS;
    localparam int LEN_BITS = fetch_geom_pkg::LEN_BITS;
    localparam int BUF_BYTES = LINE_COUNT * LINE_BYTES;
    localparam int PTR_BITS = $clog2(BUF_BYTES);
    localparam int IDX_BITS = $clog2(LINE_COUNT);

    typedef struct packed {
        logic fill_valid;
        logic [IDX_BITS-1:0] fill_index;
        logic is_init;
        logic [PTR_BITS-1:0] init_bip;
        logic is_resteer;
        logic [PTR_BITS-1:0] wb_bip;
        logic is_branch;
        logic [PTR_BITS-1:0] bp_bip;
        logic [LEN_BITS-1:0] length;
        logic stall;
        logic exp_pv;
        logic [PTR_BITS-1:0] exp_new;
        logic [PTR_BITS-1:0] exp_old;
    } step_t;

    logic clk;
    logic rst;
    logic fill_valid;
    logic [IDX_BITS-1:0] fill_index;
    logic [LINE_BITS-1:0] fill_data;
    logic is_init;
    logic [PTR_BITS-1:0] init_bip;
    logic is_resteer;
    logic [PTR_BITS-1:0] wb_bip;
    logic is_branch;
    logic [PTR_BITS-1:0] bp_bip;
    logic [LEN_BITS-1:0] length;
    logic stall;
    logic [LINE_BITS-1:0] packet_out;
    logic packet_valid;
    logic [PTR_BITS-1:0] old_bip;
    logic [PTR_BITS-1:0] new_bip;
    logic [LINE_COUNT-1:0] line_valid;

    step_t steps[$];
    bit table_ready = 1'b0;
    int errors = 0;
    int cycles = 0;
    int cycle_limit;

    // reference state
    logic [LINE_BITS-1:0] m_line [LINE_COUNT];
    logic [LINE_COUNT-1:0] m_valid;
    logic [PTR_BITS-1:0] m_bip;

    tb_clock #(.PERIOD(40), .RESET_CYCLES(10)) u_clock (.clk(clk), .rst(rst));

    fetch_top DUT (
        .clk(clk), .rst(rst),
        .fill_valid(fill_valid), .fill_index(fill_index), .fill_data(fill_data),
        .is_init(is_init), .init_bip(init_bip),
        .is_resteer(is_resteer), .wb_bip(wb_bip),
        .is_branch(is_branch), .bp_bip(bp_bip),
        .length(length), .stall(stall),
        .packet_out(packet_out), .packet_valid(packet_valid),
        .old_bip(old_bip), .new_bip(new_bip), .line_valid(line_valid)
    );

    task automatic add_step(input int fv, input int fidx, input int ini, input int ibip,
                            input int rs, input int wbip, input int br, input int bbip,
                            input int len, input int stl, input int pv, input int nbip,
                            input int obip);
        step_t s;
        s.fill_valid = 1'(fv);
        s.fill_index = IDX_BITS'(fidx);
        s.is_init = 1'(ini);
        s.init_bip = PTR_BITS'(ibip);
        s.is_resteer = 1'(rs);
        s.wb_bip = PTR_BITS'(wbip);
        s.is_branch = 1'(br);
        s.bp_bip = PTR_BITS'(bbip);
        s.length = LEN_BITS'(len);
        s.stall = 1'(stl);
        s.exp_pv = 1'(pv);
        s.exp_new = PTR_BITS'(nbip);
        s.exp_old = PTR_BITS'(obip);
        steps.push_back(s);
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////
    // expected values hold at the falling edge after the step's clock edge
    // fv idx | init bip | rst bip | br bip | len stall | pv new old
    task automatic build_table();
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 0, 0, 0, 'h00, 'h00);
        add_step(1, 0, 0, 'h00, 0, 'h00, 0, 'h00, 0, 0, 0, 'h00, 'h00);
        add_step(1, 1, 0, 'h00, 0, 'h00, 0, 'h00, 0, 0, 1, 'h00, 'h00);
        add_step(1, 2, 0, 'h00, 0, 'h00, 0, 'h00, 5, 0, 1, 'h0a, 'h05);
        add_step(1, 3, 0, 'h00, 0, 'h00, 0, 'h00, 3, 0, 1, 'h0b, 'h08);
        // leaves line 0
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 12, 0, 1, 'h20, 'h14);
        // window needs line 0, which is gone
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 30, 0, 0, 'h32, 'h14);
        add_step(1, 0, 0, 'h00, 0, 'h00, 0, 'h00, 30, 0, 1, 'h32, 'h14);
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 13, 0, 1, 'h2e, 'h21);
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 30, 0, 0, 'h1d, 'h3f);
        // packet from line 3 into line 0
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 0, 0, 1, 'h3f, 'h3f);
        add_step(1, 1, 0, 'h00, 0, 'h00, 0, 'h00, 1, 0, 1, 'h00, 'h3f);
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 1, 0, 1, 'h01, 'h00);
        // redirect priority
        add_step(0, 0, 1, 'h22, 1, 'h10, 1, 'h30, 1, 0, 0, 'h22, 'h22);
        add_step(0, 0, 0, 'h00, 1, 'h15, 1, 'h30, 1, 0, 0, 'h15, 'h15);
        add_step(0, 0, 0, 'h00, 0, 'h00, 1, 'h07, 0, 0, 0, 'h07, 'h07);
        add_step(1, 0, 0, 'h00, 0, 'h00, 0, 'h00, 0, 0, 0, 'h07, 'h07);
        add_step(1, 1, 0, 'h00, 0, 'h00, 0, 'h00, 0, 0, 1, 'h07, 'h07);
        // stall with fill, then stall with redirect
        add_step(1, 2, 0, 'h00, 0, 'h00, 0, 'h00, 20, 1, 1, 'h1b, 'h07);
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 20, 1, 1, 'h1b, 'h07);
        add_step(0, 0, 0, 'h00, 0, 'h00, 1, 'h30, 0, 1, 0, 'h30, 'h07);
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 20, 0, 0, 'h2f, 'h1b);
        add_step(1, 3, 0, 'h00, 0, 'h00, 0, 'h00, 0, 0, 1, 'h1b, 'h1b);
        add_step(0, 0, 0, 'h00, 0, 'h00, 0, 'h00, 0, 0, 1, 'h1b, 'h1b);
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic [PTR_BITS-1:0] model_window(input step_t s);
        int sum;
        if (s.is_init) return s.init_bip;
        if (s.is_resteer) return s.wb_bip;
        if (s.is_branch) return s.bp_bip;
        sum = int'(m_bip) + int'(s.length);
        return PTR_BITS'(sum % BUF_BYTES);
    endfunction

    function automatic logic model_ok(input logic [PTR_BITS-1:0] win);
        int idx;
        idx = int'(win) / LINE_BYTES;
        return m_valid[idx] && m_valid[(idx + 1) % LINE_COUNT];
    endfunction

    function automatic logic [LINE_BITS-1:0] model_packet(input logic [PTR_BITS-1:0] win);
        logic [LINE_BITS-1:0] pkt;
        int b;
        pkt = '0;
        for (int k = 0; k < LINE_BYTES; k++) begin
            b = (int'(win) + k) % BUF_BYTES;
            pkt[8*k +: 8] = m_line[b / LINE_BYTES][8*(b % LINE_BYTES) +: 8];
        end
        return pkt;
    endfunction

    // state after the clock edge that samples this step
    task automatic model_apply(input step_t s, input logic [LINE_BITS-1:0] data);
        logic redir;
        logic adv;
        logic [PTR_BITS-1:0] win;
        int old_line;
        redir = s.is_init || s.is_resteer || s.is_branch;
        win = model_window(s);
        adv = !s.stall && (redir || model_ok(win));
        old_line = int'(m_bip) / LINE_BYTES;
        if (adv && redir) begin
            m_valid = '0;
        end else if (adv && (old_line != int'(win) / LINE_BYTES)) begin
            m_valid[old_line] = 1'b0;
        end
        if (adv) begin
            m_bip = win;
        end
        if (s.fill_valid) begin
            m_line[s.fill_index] = data;
            m_valid[s.fill_index] = 1'b1;
        end
    endtask

    task automatic drive_step(input step_t s);
        fill_valid = s.fill_valid;
        fill_index = s.fill_index;
        fill_data = s.fill_valid ? {$urandom, $urandom, $urandom, $urandom} : '0;
        is_init = s.is_init;
        init_bip = s.init_bip;
        is_resteer = s.is_resteer;
        wb_bip = s.wb_bip;
        is_branch = s.is_branch;
        bp_bip = s.bp_bip;
        length = s.length;
        stall = s.stall;
    endtask

    task automatic check_step(input int i, input step_t s);
        logic [LINE_BITS-1:0] exp_pkt;
        exp_pkt = model_packet(model_window(s));
        assert (packet_valid === s.exp_pv) else begin
            errors++;
            $display("ERR step %0d packet_valid exp %h got %h", i, s.exp_pv, packet_valid);
        end
        assert (new_bip === s.exp_new) else begin
            errors++;
            $display("ERR step %0d new_bip exp %h got %h", i, s.exp_new, new_bip);
        end
        assert (old_bip === s.exp_old) else begin
            errors++;
            $display("ERR step %0d old_bip exp %h got %h", i, s.exp_old, old_bip);
        end
        assert (line_valid === m_valid) else begin
            errors++;
            $display("ERR step %0d line_valid exp %h got %h", i, m_valid, line_valid);
        end
        // packet bytes only mean something when both lines are present
        if (s.exp_pv) begin
            assert (packet_out === exp_pkt) else begin
                errors++;
                $display("ERR step %0d packet_out exp %h got %h", i, exp_pkt, packet_out);
            end
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        void'($urandom(32'hcfdc_9908));
        fill_valid = 1'b0;
        fill_index = '0;
        fill_data = '0;
        is_init = 1'b0;
        init_bip = '0;
        is_resteer = 1'b0;
        wb_bip = '0;
        is_branch = 1'b0;
        bp_bip = '0;
        length = '0;
        stall = 1'b0;
        m_valid = '0;
        m_bip = '0;
        for (int n = 0; n < LINE_COUNT; n++) begin
            m_line[n] = '0;
        end
        build_table();
        table_ready = 1'b1;

        wait (rst === 1'b1);
        @(negedge rst);
        for (int i = 0; i < steps.size(); i++) begin
            drive_step(steps[i]);
            model_apply(steps[i], fill_data);
            @(negedge clk);
            check_step(i, steps[i]);
        end

        $display("%0d steps run, %0d errors", steps.size(), errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // cycle limit scales with the table
    initial begin
        wait (table_ready);
        cycle_limit = 20 + 4 * steps.size();
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the step loop did not finish", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
fetch_geom_pkg.sv
redirect_pkg.sv
bip_control.sv
ibuf_lines.sv
packet_extract.sv
fetch_top.sv
tb_clock.sv
fetch_chk.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the fetch aligner testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_top -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "Simulation finished: FAIL" "$LOG"
status=$?
if [ $status -eq 0 ]; then
    echo "run failed, see $LOG"
    exit 1
fi

echo "run passed"
exit 0
